// File: transform_pipeline.f
+incdir+test
common/transform_pkg.sv
vertex_shader/vertex_shader.sv
vertex_post_processor/serial_divider.sv
vertex_post_processor/vertex_post_processor.sv
design/vertex_buffer.sv
primitive_assembler/primitive_assembler.sv
design/transform_pipeline.sv
test/tb_transform_pipeline.sv

// File: Bender.yml
package:
  name: transform_pipeline

sources:
  - common/transform_pkg.sv
  - vertex_shader/vertex_shader.sv
  - vertex_post_processor/serial_divider.sv
  - vertex_post_processor/vertex_post_processor.sv
  - design/vertex_buffer.sv
  - primitive_assembler/primitive_assembler.sv
  - design/transform_pipeline.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_transform_pipeline.sv

// File: test/transform_model.svh
`ifndef TRANSFORM_MODEL_SVH
`define TRANSFORM_MODEL_SVH

logic [31:0] lfsr_state;

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

function automatic clip_vertex_t model_transform(input mat4_t mvp, input obj_vertex_t v);
    clip_vertex_t c;
    int vin [4];
    int acc [4];
    vin[0] = int'($signed(v.x));
    vin[1] = int'($signed(v.y));
    vin[2] = int'($signed(v.z));
    vin[3] = 1 << VTX_FRAC;
    for (int r = 0; r < 4; r++) begin
        acc[r] = 0;
        for (int col = 0; col < 4; col++) begin
            acc[r] = acc[r] + ((int'($signed(mvp.m[r][col])) * vin[col]) >>> VTX_FRAC);
        end
    end
    // Wrap to the vertex width
    c.x = fix_t'(acc[0]);
    c.y = fix_t'(acc[1]);
    c.z = fix_t'(acc[2]);
    c.w = fix_t'(acc[3]);
    return c;
endfunction

function automatic screen_vertex_t model_project(input clip_vertex_t c);
    screen_vertex_t s;
    int comp [3];
    int nd [3];
    int w;
    int mag;
    comp[0] = int'($signed(c.x));
    comp[1] = int'($signed(c.y));
    comp[2] = int'($signed(c.z));
    w = int'($signed(c.w));
    s = '0;
    s.invalid = 1'b1;
    if (w <= 0) return s;
    for (int i = 0; i < 3; i++) begin
        mag = (comp[i] < 0) ? -comp[i] : comp[i];
        if (mag > w) return s;
        nd[i] = (mag << VTX_FRAC) / w;
        if (comp[i] < 0) nd[i] = -nd[i];
    end
    s.invalid = 1'b0;
    s.px    = pix_t'(((nd[0] + (1 << VTX_FRAC)) * (SCREEN_W - 1)) >> (VTX_FRAC + 1));
    s.py    = pix_t'((((1 << VTX_FRAC) - nd[1]) * (SCREEN_H - 1)) >> (VTX_FRAC + 1));
    s.depth = DEPTH_W'(((nd[2] + (1 << VTX_FRAC)) * ((1 << DEPTH_W) - 1)) >> (VTX_FRAC + 1));
    return s;
endfunction

function automatic triangle_t model_triangle(input screen_vertex_t a, input screen_vertex_t b,
                                             input screen_vertex_t c);
    triangle_t t;
    t.v[0] = a;
    t.v[1] = b;
    t.v[2] = c;
    t.min_x = a.px;
    t.max_x = a.px;
    t.min_y = a.py;
    t.max_y = a.py;
    for (int i = 1; i < 3; i++) begin
        if (t.v[i].px < t.min_x) t.min_x = t.v[i].px;
        if (t.v[i].px > t.max_x) t.max_x = t.v[i].px;
        if (t.v[i].py < t.min_y) t.min_y = t.v[i].py;
        if (t.v[i].py > t.max_y) t.max_y = t.v[i].py;
    end
    return t;
endfunction

`endif

// File: test/tb_transform_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_transform_pipeline;
    import transform_pkg::*;

    `include "transform_model.svh"

    localparam logic [31:0] LFSR_SEED = 32'h2dbe_a534;
    localparam int NUM_VERTS    = 32;
    localparam int IDX_BITS     = 5;
    localparam int NUM_TRIS     = 24;
    localparam int PAT_LEN      = 256;
    localparam int WAIT_LIMIT   = 2000;
    localparam int FINISH_LIMIT = 8000;

    logic                 clk;
    logic                 rstn;
    mat4_t                i_mvp;
    logic                 i_mvp_dv;
    obj_vertex_t          i_vertex;
    logic                 i_vertex_dv;
    logic                 i_vertex_last;
    logic [TADDR_W:0]     i_num_tris;
    logic                 i_triangle_ready;
    tri_idx_t             i_index;
    logic                 o_vertex_ready;
    logic [TADDR_W-1:0]   o_index_addr;
    logic                 o_index_rd;
    triangle_t            o_triangle;
    logic                 o_triangle_dv;
    logic                 o_finished;

    tri_idx_t             idx_mem [MAX_TRIS];
    logic                 ready_pat [PAT_LEN];
    logic                 ready_random;
    int                   pat_pos;
    logic                 rd_seen;
    logic [TADDR_W-1:0]   rd_addr;
    int                   rd_count;
    triangle_t            exp_q [$];
    int                   rx_count;
    logic                 finished_seen;
    int                   errors;
    logic                 timed_out;
    string                cur_test;

    transform_pipeline i_dut (
        .clk              (clk),
        .rstn             (rstn),
        .i_mvp            (i_mvp),
        .i_mvp_dv         (i_mvp_dv),
        .i_vertex         (i_vertex),
        .i_vertex_dv      (i_vertex_dv),
        .i_vertex_last    (i_vertex_last),
        .i_num_tris       (i_num_tris),
        .i_triangle_ready (i_triangle_ready),
        .i_index          (i_index),
        .o_vertex_ready   (o_vertex_ready),
        .o_index_addr     (o_index_addr),
        .o_index_rd       (o_index_rd),
        .o_triangle       (o_triangle),
        .o_triangle_dv    (o_triangle_dv),
        .o_finished       (o_finished)
    );

    always #10 clk = ~clk;

    // Index memory with one cycle read, plus consumer ready pattern
    always @(posedge clk) begin
        rd_seen = o_index_rd;
        rd_addr = o_index_addr;
        #1;
        if (rd_seen) i_index = idx_mem[rd_addr];
        i_triangle_ready = ready_random ? ready_pat[pat_pos] : 1'b1;
        pat_pos = (pat_pos + 1) % PAT_LEN;
    end

    task automatic check_triangle();
        triangle_t exp;
        if (finished_seen) begin
            errors++;
            $display("%s: triangle output after finished was raised", cur_test);
        end
        if (rx_count >= exp_q.size()) begin
            errors++;
            $display("%s: unexpected extra triangle %0d", cur_test, rx_count);
        end else begin
            exp = exp_q[rx_count];
            if (o_triangle.v !== exp.v) begin
                errors++;
                $display("mismatch %s: triangle %0d vertices expected %h actual %h",
                         cur_test, rx_count, exp.v, o_triangle.v);
            end
            if ({o_triangle.min_x, o_triangle.min_y, o_triangle.max_x, o_triangle.max_y}
                    !== {exp.min_x, exp.min_y, exp.max_x, exp.max_y}) begin
                errors++;
                $display("mismatch %s: triangle %0d bbox expected %h actual %h", cur_test,
                         rx_count, {exp.min_x, exp.min_y, exp.max_x, exp.max_y},
                         {o_triangle.min_x, o_triangle.min_y, o_triangle.max_x,
                          o_triangle.max_y});
            end
        end
        rx_count++;
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            if (o_index_rd && !i_triangle_ready) begin
                errors++;
                $display("%s: index read while triangle ready was low", cur_test);
            end
            // Index reads walk the triangles in order
            if (o_index_rd) begin
                if (o_index_addr !== TADDR_W'(rd_count)) begin
                    errors++;
                    $display("mismatch %s: index address expected %0d actual %0d",
                             cur_test, rd_count, o_index_addr);
                end
                rd_count++;
            end
            if (o_triangle_dv) check_triangle();
            if (o_finished && !finished_seen) begin
                finished_seen = 1'b1;
                if (rx_count != exp_q.size()) begin
                    errors++;
                    $display("mismatch %s: triangles before finished expected %0d actual %0d",
                             cur_test, exp_q.size(), rx_count);
                end
            end
        end
    end

    function automatic mat4_t make_matrix(input int kind);
        mat4_t m;
        int val;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (kind == 0) begin
                    if (r != c) val = 0;
                    else if (r == 3) val = 1 << VTX_FRAC;
                    else val = 128 + int'(rand_bits(7));
                end else if (r == c && r < 3) begin
                    val = 64 + int'(rand_bits(8));
                end else if (r == 3 && c == 3) begin
                    val = 192 + int'(rand_bits(8));
                end else begin
                    val = int'(rand_bits(6)) - 32;
                end
                m.m[r][c] = fix_t'(val);
            end
        end
        return m;
    endfunction

    function automatic obj_vertex_t make_vertex();
        obj_vertex_t v;
        v.x = fix_t'(int'(rand_bits(9)) - 256);
        v.y = fix_t'(int'(rand_bits(9)) - 256);
        v.z = fix_t'(int'(rand_bits(9)) - 256);
        return v;
    endfunction

    task automatic run_frame(input string name, input int kind, input logic use_random_ready);
        mat4_t          mvp;
        obj_vertex_t    vtx [NUM_VERTS];
        screen_vertex_t sv [NUM_VERTS];
        tri_idx_t       ti;
        int             cycles;
        cur_test = name;
        mvp = make_matrix(kind);
        for (int v = 0; v < NUM_VERTS; v++) begin
            vtx[v] = make_vertex();
            sv[v] = model_project(model_transform(mvp, vtx[v]));
        end
        exp_q.delete();
        for (int t = 0; t < NUM_TRIS; t++) begin
            for (int k = 0; k < 3; k++) ti.idx[k] = VADDR_W'(rand_bits(IDX_BITS));
            idx_mem[t] = ti;
            if (!(sv[ti.idx[0]].invalid || sv[ti.idx[1]].invalid || sv[ti.idx[2]].invalid)) begin
                exp_q.push_back(model_triangle(sv[ti.idx[0]], sv[ti.idx[1]], sv[ti.idx[2]]));
            end
        end
        for (int p = 0; p < PAT_LEN; p++) ready_pat[p] = (rand_bits(2) != 0);
        $display("%s: %0d of %0d triangles survive", name, exp_q.size(), NUM_TRIS);

        @(posedge clk);
        #1;
        rstn = 1'b0;
        i_mvp_dv = 1'b0;
        i_vertex_dv = 1'b0;
        i_vertex_last = 1'b0;
        ready_random = use_random_ready;
        rx_count = 0;
        rd_count = 0;
        finished_seen = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        i_num_tris = (TADDR_W + 1)'(NUM_TRIS);
        i_mvp = mvp;
        i_mvp_dv = 1'b1;
        @(posedge clk);
        #1;
        i_mvp_dv = 1'b0;

        for (int v = 0; v < NUM_VERTS; v++) begin
            cycles = 0;
            while (!o_vertex_ready && cycles < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (!o_vertex_ready) begin
                errors++;
                timed_out = 1'b1;
                $display("%s: timeout waiting for vertex ready at vertex %0d", name, v);
                return;
            end
            i_vertex = vtx[v];
            i_vertex_last = (v == NUM_VERTS - 1);
            i_vertex_dv = 1'b1;
            @(posedge clk);
            #1;
            i_vertex_dv = 1'b0;
            i_vertex_last = 1'b0;
        end

        cycles = 0;
        while (!o_finished && cycles < FINISH_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!o_finished) begin
            errors++;
            timed_out = 1'b1;
            $display("%s: timeout waiting for finished", name);
            return;
        end
        // Drain window for stray triangles
        repeat (4) @(posedge clk);
        #1;
        if (rx_count != exp_q.size()) begin
            errors++;
            $display("mismatch %s: triangle count expected %0d actual %0d",
                     name, exp_q.size(), rx_count);
        end
        if (rd_count != NUM_TRIS) begin
            errors++;
            $display("mismatch %s: index read count expected %0d actual %0d",
                     name, NUM_TRIS, rd_count);
        end
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        i_mvp = '0;
        i_mvp_dv = 1'b0;
        i_vertex = '0;
        i_vertex_dv = 1'b0;
        i_vertex_last = 1'b0;
        i_num_tris = '0;
        i_triangle_ready = 1'b1;
        i_index = '0;
        ready_random = 1'b0;
        pat_pos = 0;
        rd_count = 0;
        rx_count = 0;
        finished_seen = 1'b0;
        errors = 0;
        timed_out = 1'b0;
        lfsr_state = LFSR_SEED;
        cur_test = "init";

        run_frame("identity_scaled", 0, 1'b0);
        if (!timed_out) run_frame("perspective", 1, 1'b1);
        if (!timed_out) run_frame("second_frame", 1, 1'b1);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/transform_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module transform_pipeline (
    input  wire logic                                clk,
    input  wire logic                                rstn,
    input  wire transform_pkg::mat4_t                i_mvp,
    input  wire logic                                i_mvp_dv,
    input  wire transform_pkg::obj_vertex_t          i_vertex,
    input  wire logic                                i_vertex_dv,
    input  wire logic                                i_vertex_last,
    input  wire logic [transform_pkg::TADDR_W:0]     i_num_tris,
    input  wire logic                                i_triangle_ready,
    input  wire transform_pkg::tri_idx_t             i_index,
    output logic                                     o_vertex_ready,
    output logic [transform_pkg::TADDR_W-1:0]        o_index_addr,
    output logic                                     o_index_rd,
    output transform_pkg::triangle_t                 o_triangle,
    output logic                                     o_triangle_dv,
    output logic                                     o_finished
);
    import transform_pkg::*;

    clip_vertex_t         vs_clip;
    logic                 vs_clip_dv;
    logic                 vs_last;
    logic                 vpp_ready;
    screen_vertex_t       vpp_vertex;
    logic                 vpp_done;
    logic                 vpp_last;
    logic [VADDR_W-1:0]   wr_addr;
    logic                 pa_start;
    logic                 pa_vtx_rd;
    tri_idx_t             pa_vtx_addr;
    screen_vertex_t [0:2] buf_data;
    logic                 buf_dv;

    vertex_shader u_vs (
        .clk         (clk),
        .rstn        (rstn),
        .i_enable    (vpp_ready),
        .i_mvp       (i_mvp),
        .i_mvp_dv    (i_mvp_dv),
        .i_vertex    (i_vertex),
        .i_vertex_dv (i_vertex_dv),
        .i_last      (i_vertex_last),
        .o_ready     (o_vertex_ready),
        .o_clip      (vs_clip),
        .o_clip_dv   (vs_clip_dv),
        .o_last      (vs_last)
    );

    vertex_post_processor u_vpp (
        .clk       (clk),
        .rstn      (rstn),
        .i_clip    (vs_clip),
        .i_clip_dv (vs_clip_dv),
        .i_last    (vs_last),
        .o_ready   (vpp_ready),
        .o_vertex  (vpp_vertex),
        .o_done    (vpp_done),
        .o_last    (vpp_last)
    );

    // Vertices land in arrival order, invalid ones included
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_addr  <= '0;
            pa_start <= 1'b0;
        end else begin
            if (vpp_done) wr_addr <= wr_addr + 1'b1;
            pa_start <= vpp_done && vpp_last;
        end
    end

    vertex_buffer u_vbuf (
        .clk       (clk),
        .i_wr_en   (vpp_done),
        .i_wr_addr (wr_addr),
        .i_wr_data (vpp_vertex),
        .i_rd_en   (pa_vtx_rd),
        .i_rd_addr (pa_vtx_addr),
        .o_rd_data (buf_data),
        .o_rd_dv   (buf_dv)
    );

    primitive_assembler u_pa (
        .clk              (clk),
        .rstn             (rstn),
        .i_start          (pa_start),
        .i_num_tris       (i_num_tris),
        .i_triangle_ready (i_triangle_ready),
        .i_index          (i_index),
        .i_vtx_data       (buf_data),
        .i_vtx_dv         (buf_dv),
        .o_index_addr     (o_index_addr),
        .o_index_rd       (o_index_rd),
        .o_vtx_rd         (pa_vtx_rd),
        .o_vtx_addr       (pa_vtx_addr),
        .o_triangle       (o_triangle),
        .o_triangle_dv    (o_triangle_dv),
        .o_finished       (o_finished)
    );

endmodule

`default_nettype wire

// File: primitive_assembler/primitive_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module primitive_assembler (
    input  wire logic                                 clk,
    input  wire logic                                 rstn,
    input  wire logic                                 i_start,
    input  wire logic [transform_pkg::TADDR_W:0]      i_num_tris,
    input  wire logic                                 i_triangle_ready,
    input  wire transform_pkg::tri_idx_t              i_index,
    input  wire transform_pkg::screen_vertex_t [0:2]  i_vtx_data,
    input  wire logic                                 i_vtx_dv,
    output logic [transform_pkg::TADDR_W-1:0]         o_index_addr,
    output logic                                      o_index_rd,
    output logic                                      o_vtx_rd,
    output transform_pkg::tri_idx_t                   o_vtx_addr,
    output transform_pkg::triangle_t                  o_triangle,
    output logic                                      o_triangle_dv,
    output logic                                      o_finished
);
    import transform_pkg::*;

    pa_state_e        state;
    logic [TADDR_W:0] tri_cnt;
    logic [TADDR_W:0] num_tris;
    logic             culled;

    function automatic pix_t min3(input pix_t a, input pix_t b, input pix_t c);
        pix_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic pix_t max3(input pix_t a, input pix_t b, input pix_t c);
        pix_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Index read only in a cycle where the consumer is ready
    assign o_index_rd   = (state == PA_WAIT) && i_triangle_ready;
    assign o_index_addr = tri_cnt[TADDR_W-1:0];
    assign culled = i_vtx_data[0].invalid || i_vtx_data[1].invalid || i_vtx_data[2].invalid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= PA_IDLE;
            tri_cnt       <= '0;
            o_vtx_rd      <= 1'b0;
            o_triangle_dv <= 1'b0;
            o_finished    <= 1'b0;
        end else begin
            o_vtx_rd      <= 1'b0;
            o_triangle_dv <= 1'b0;
            case (state)
                PA_IDLE: if (i_start) begin
                    tri_cnt <= '0;
                    state   <= (i_num_tris == '0) ? PA_DONE : PA_WAIT;
                end
                PA_WAIT: if (i_triangle_ready) state <= PA_INDEX;
                PA_INDEX: begin
                    o_vtx_rd <= 1'b1;
                    state    <= PA_VTX;
                end
                PA_VTX: if (i_vtx_dv) begin
                    o_triangle_dv <= !culled;
                    tri_cnt       <= tri_cnt + 1'b1;
                    state <= (tri_cnt + 1'b1 == num_tris) ? PA_DONE : PA_WAIT;
                end
                PA_DONE: o_finished <= 1'b1;
                default: state <= PA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PA_IDLE && i_start) num_tris <= i_num_tris;
        if (state == PA_INDEX) o_vtx_addr <= i_index;
        if (state == PA_VTX && i_vtx_dv) begin
            o_triangle.v     <= i_vtx_data;
            o_triangle.min_x <= min3(i_vtx_data[0].px, i_vtx_data[1].px, i_vtx_data[2].px);
            o_triangle.min_y <= min3(i_vtx_data[0].py, i_vtx_data[1].py, i_vtx_data[2].py);
            o_triangle.max_x <= max3(i_vtx_data[0].px, i_vtx_data[1].px, i_vtx_data[2].px);
            o_triangle.max_y <= max3(i_vtx_data[0].py, i_vtx_data[1].py, i_vtx_data[2].py);
        end
    end

endmodule

`default_nettype wire

// File: design/vertex_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_buffer (
    input  wire logic                                 clk,
    input  wire logic                                 i_wr_en,
    input  wire logic [transform_pkg::VADDR_W-1:0]    i_wr_addr,
    input  wire transform_pkg::screen_vertex_t        i_wr_data,
    input  wire logic                                 i_rd_en,
    input  wire transform_pkg::tri_idx_t              i_rd_addr,
    output transform_pkg::screen_vertex_t [0:2]       o_rd_data,
    output logic                                      o_rd_dv
);
    import transform_pkg::*;

    screen_vertex_t mem [MAX_VERTS];

    always_ff @(posedge clk) begin
        if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
        // One port per triangle corner
        if (i_rd_en) begin
            for (int p = 0; p < 3; p++) begin
                o_rd_data[p] <= mem[i_rd_addr.idx[p]];
            end
        end
        o_rd_dv <= i_rd_en;
    end

endmodule

`default_nettype wire

// File: vertex_post_processor/vertex_post_processor.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_post_processor (
    input  wire logic                          clk,
    input  wire logic                          rstn,
    input  wire transform_pkg::clip_vertex_t   i_clip,
    input  wire logic                          i_clip_dv,
    input  wire logic                          i_last,
    output logic                               o_ready,
    output transform_pkg::screen_vertex_t      o_vertex,
    output logic                               o_done,
    output logic                               o_last
);
    import transform_pkg::*;

    vpp_state_e       state;
    clip_vertex_t     clip;
    logic [1:0]       comp;
    logic [1:0]       next_comp;
    fix_t             dsel;
    logic             neg;
    fix_t             nd;
    fix_t             nd_x;
    fix_t             nd_y;
    logic             invalid;
    logic             div_start;
    logic             div_done;
    logic [DIV_W-1:0] dividend;
    logic [QUO_W-1:0] quotient;

    function automatic logic [VTX_W-1:0] mag(input fix_t v);
        return v[VTX_W-1] ? VTX_W'(-v) : VTX_W'(v);
    endfunction

    // Biased NDC in [0, 2.0] times range, then halved
    function automatic pix_t scale(input logic [VTX_W-1:0] biased, input pix_t range);
        logic [VTX_W+PIX_W-1:0] prod;
        prod = biased * range;
        return pix_t'(prod >> (VTX_FRAC + 1));
    endfunction

    assign o_ready = (state == VPP_IDLE);

    always_comb begin
        invalid = (clip.w <= 0) || (mag(clip.x) > $unsigned(clip.w))
               || (mag(clip.y) > $unsigned(clip.w)) || (mag(clip.z) > $unsigned(clip.w));
        next_comp = (state == VPP_TEST) ? 2'd0 : comp + 2'd1;
        div_start = ((state == VPP_TEST) && !invalid)
                 || ((state == VPP_DIV) && div_done && (comp != 2'd2));
        case (next_comp)
            2'd0:    dsel = clip.x;
            2'd1:    dsel = clip.y;
            default: dsel = clip.z;
        endcase
        case (comp)
            2'd0:    neg = clip.x[VTX_W-1];
            2'd1:    neg = clip.y[VTX_W-1];
            default: neg = clip.z[VTX_W-1];
        endcase
        dividend = {mag(dsel), VTX_FRAC'(0)};
        nd = neg ? -fix_t'(quotient) : fix_t'(quotient);
    end

    serial_divider u_div (
        .clk        (clk),
        .rstn       (rstn),
        .i_start    (div_start),
        .i_dividend (dividend),
        .i_divisor  ($unsigned(clip.w)),
        .o_quotient (quotient),
        .o_done     (div_done)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= VPP_IDLE;
            comp   <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (div_start) comp <= next_comp;
            case (state)
                VPP_IDLE: if (i_clip_dv) state <= VPP_TEST;
                VPP_TEST: begin
                    state  <= invalid ? VPP_IDLE : VPP_DIV;
                    o_done <= invalid;
                end
                VPP_DIV: if (div_done && comp == 2'd2) begin
                    state  <= VPP_IDLE;
                    o_done <= 1'b1;
                end
                default: state <= VPP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == VPP_IDLE && i_clip_dv) begin
            clip   <= i_clip;
            o_last <= i_last;
        end
        if (state == VPP_TEST && invalid) begin
            o_vertex <= '{px: '0, py: '0, depth: '0, invalid: 1'b1};
        end
        if (state == VPP_DIV && div_done) begin
            if (comp == 2'd0) nd_x <= nd;
            if (comp == 2'd1) nd_y <= nd;
            // Last quotient is z, mapped straight from the divider
            if (comp == 2'd2) begin
                o_vertex.px      <= scale(nd_x + FIX_ONE, pix_t'(SCREEN_W - 1));
                o_vertex.py      <= scale(FIX_ONE - nd_y, pix_t'(SCREEN_H - 1));
                o_vertex.depth   <= DEPTH_W'(scale(nd + FIX_ONE, pix_t'(DEPTH_MAX)));
                o_vertex.invalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: vertex_post_processor/serial_divider.sv
`timescale 1ns/1ps
`default_nettype none

module serial_divider (
    input  wire logic                              clk,
    input  wire logic                              rstn,
    input  wire logic                              i_start,
    input  wire logic [transform_pkg::DIV_W-1:0]   i_dividend,
    input  wire logic [transform_pkg::VTX_W-1:0]   i_divisor,
    output logic [transform_pkg::QUO_W-1:0]        o_quotient,
    output logic                                   o_done
);
    import transform_pkg::*;

    div_state_e               state;
    logic [$clog2(QUO_W)-1:0] cnt;
    logic [VTX_W-1:0]         divisor;
    logic [VTX_W-1:0]         rem;
    logic [QUO_W-1:0]         low_bits;
    logic [VTX_W:0]           trial;
    logic                     take;

    always_comb begin
        trial = {rem, low_bits[QUO_W-1]};
        take  = trial >= {1'b0, divisor};
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= DIV_IDLE;
            cnt    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (state == DIV_IDLE && i_start) begin
                state <= DIV_RUN;
                cnt   <= '0;
            end else if (state == DIV_RUN) begin
                cnt <= cnt + 1'b1;
                if (cnt == QUO_W - 1) begin
                    state  <= DIV_IDLE;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // Upper dividend bits start out below the divisor
    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && i_start) begin
            rem      <= VTX_W'(i_dividend[DIV_W-1:QUO_W]);
            low_bits <= i_dividend[QUO_W-1:0];
            divisor  <= i_divisor;
        end else if (state == DIV_RUN) begin
            rem        <= take ? VTX_W'(trial - divisor) : trial[VTX_W-1:0];
            low_bits   <= low_bits << 1;
            o_quotient <= {o_quotient[QUO_W-2:0], take};
        end
    end

endmodule

`default_nettype wire

// File: vertex_shader/vertex_shader.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_shader (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic                        i_enable,
    input  wire transform_pkg::mat4_t        i_mvp,
    input  wire logic                        i_mvp_dv,
    input  wire transform_pkg::obj_vertex_t  i_vertex,
    input  wire logic                        i_vertex_dv,
    input  wire logic                        i_last,
    output logic                             o_ready,
    output transform_pkg::clip_vertex_t      o_clip,
    output logic                             o_clip_dv,
    output logic                             o_last
);
    import transform_pkg::*;

    vs_state_e                 state;
    mat4_t                     mvp;
    obj_vertex_t               vtx;
    fix_t                      vin [4];
    logic signed [2*VTX_W-1:0] prod [4];
    fix_t                      row_sum;
    logic [1:0]                row;

    // Busy while a row is in flight or a result is being handed over
    assign o_ready = (state == VS_IDLE) && !o_clip_dv && i_enable;

    always_comb begin
        row = state[1:0];
        vin[0] = vtx.x;
        vin[1] = vtx.y;
        vin[2] = vtx.z;
        vin[3] = FIX_ONE;
        row_sum = '0;
        for (int c = 0; c < 4; c++) begin
            prod[c] = mvp.m[row][c] * vin[c];
            row_sum = row_sum + fix_t'(prod[c] >>> VTX_FRAC);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= VS_IDLE;
            o_clip_dv <= 1'b0;
        end else begin
            o_clip_dv <= 1'b0;
            case (state)
                VS_IDLE: if (i_vertex_dv && o_ready) state <= VS_ROW0;
                VS_ROW0: state <= VS_ROW1;
                VS_ROW1: state <= VS_ROW2;
                VS_ROW2: state <= VS_ROW3;
                VS_ROW3: begin
                    state     <= VS_IDLE;
                    o_clip_dv <= 1'b1;
                end
                default: state <= VS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_mvp_dv) mvp <= i_mvp;
        if (state == VS_IDLE && i_vertex_dv && o_ready) begin
            vtx    <= i_vertex;
            o_last <= i_last;
        end
        case (state)
            VS_ROW0: o_clip.x <= row_sum;
            VS_ROW1: o_clip.y <= row_sum;
            VS_ROW2: o_clip.z <= row_sum;
            VS_ROW3: o_clip.w <= row_sum;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: common/transform_pkg.sv
`default_nettype none

package transform_pkg;

    localparam int VTX_W     = 16;
    localparam int VTX_FRAC  = 8;
    localparam int PIX_W     = 10;
    localparam int DEPTH_W   = 8;
    localparam int SCREEN_W  = 320;
    localparam int SCREEN_H  = 240;
    localparam int MAX_VERTS = 64;
    localparam int MAX_TRIS  = 64;
    localparam int VADDR_W   = $clog2(MAX_VERTS);
    localparam int TADDR_W   = $clog2(MAX_TRIS);

    // Perspective divide, quotient never exceeds 1.0
    localparam int DIV_W     = VTX_W + VTX_FRAC;
    localparam int QUO_W     = VTX_FRAC + 1;
    localparam int DEPTH_MAX = (1 << DEPTH_W) - 1;

    typedef logic signed [VTX_W-1:0] fix_t;
    typedef logic [PIX_W-1:0] pix_t;

    localparam fix_t FIX_ONE = fix_t'(1 << VTX_FRAC);

    // Row r, column c at m[r][c]
    typedef struct packed {
        fix_t [0:3][0:3] m;
    } mat4_t;

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } obj_vertex_t;

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
        fix_t w;
    } clip_vertex_t;

    typedef struct packed {
        pix_t               px;
        pix_t               py;
        logic [DEPTH_W-1:0] depth;
        logic               invalid;
    } screen_vertex_t;

    typedef struct packed {
        logic [0:2][VADDR_W-1:0] idx;
    } tri_idx_t;

    typedef struct packed {
        screen_vertex_t [0:2] v;
        pix_t                 min_x;
        pix_t                 min_y;
        pix_t                 max_x;
        pix_t                 max_y;
    } triangle_t;

    typedef enum logic [2:0] {
        VS_ROW0 = 3'd0,
        VS_ROW1 = 3'd1,
        VS_ROW2 = 3'd2,
        VS_ROW3 = 3'd3,
        VS_IDLE = 3'd4
    } vs_state_e;

    typedef enum logic [1:0] {VPP_IDLE, VPP_TEST, VPP_DIV} vpp_state_e;

    typedef enum logic {DIV_IDLE, DIV_RUN} div_state_e;

    typedef enum logic [2:0] {PA_IDLE, PA_WAIT, PA_INDEX, PA_VTX, PA_DONE} pa_state_e;

endpackage

`default_nettype wire
